// File: hdl/axi_bridge_pkg.sv
package axi_bridge_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 64;
    localparam int AXI_ID_WIDTH   = 4;

    typedef logic [AXI_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]   data_t;
    typedef logic [AXI_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [AXI_ID_WIDTH-1:0]     axi_id_t;
    typedef logic [1:0]                  size_t;    // Byte, half, word, double.
    typedef logic [1:0]                  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        size_t   size;
        logic    write;
        logic    instr;     // Fetch access.
        axi_id_t id;
    } bus_req_t;

    typedef struct packed {
        data_t   rdata;
        resp_t   resp;
        axi_id_t id;
    } bus_rsp_t;

    typedef struct packed {
        addr_t      addr;
        axi_id_t    id;
        logic [2:0] prot;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t id;
        resp_t   resp;
    } axi_b_t;

    typedef struct packed {
        data_t   data;
        axi_id_t id;
        resp_t   resp;
        logic    last;
    } axi_r_t;

    // Single beat address phase shared by AR and AW.
    function automatic axi_ax_t make_ax(bus_req_t req);
        axi_ax_t ax;
        ax.addr  = req.addr;
        ax.id    = req.id;
        ax.prot  = req.instr ? 3'b100 : 3'b000;
        ax.len   = 8'd0;
        ax.size  = {1'b0, req.size};
        ax.burst = BURST_INCR;
        return ax;
    endfunction

endpackage

// File: hdl/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter import axi_bridge_pkg::*; #(
    parameter axi_id_t FETCH_ID = 4'd0,
    parameter axi_id_t DATA_ID  = 4'd1
) (
    input  logic        clock,
    input  logic        rst_n_i,

    input  logic        if_addr_valid_i,
    input  logic [63:0] if_rd_addr_i,

    input  logic        mem_rw_valid_i,
    input  logic        mem_rw_req_i,
    input  logic [63:0] mem_rw_addr_i,
    input  size_t       mem_rw_size_i,
    input  data_t       mem_data_write_i,

    input  logic        release_i,
    output bus_req_t    req_o,
    output logic        req_valid_o
);

    typedef enum logic {
        IDLE,
        BUSY
    } arb_state_e;

    arb_state_e state_q;

    assign req_valid_o = (state_q == BUSY);

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (mem_rw_valid_i || if_addr_valid_i) begin
                        state_q <= BUSY;
                    end
                end
                BUSY: begin
                    if (release_i) begin
                        state_q <= IDLE;    // Transaction returned to its port.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request is captured once on grant and held while busy.
    always_ff @(posedge clock) begin
        if (state_q == IDLE) begin
            if (mem_rw_valid_i) begin
                req_o.addr  <= mem_rw_addr_i[AXI_ADDR_WIDTH-1:0];
                req_o.wdata <= mem_data_write_i;
                req_o.size  <= mem_rw_size_i;
                req_o.write <= mem_rw_req_i;
                req_o.instr <= 1'b0;
                req_o.id    <= DATA_ID;
            end else begin
                req_o.addr  <= if_rd_addr_i[AXI_ADDR_WIDTH-1:0];
                req_o.wdata <= '0;
                req_o.size  <= 2'd2;    // Word fetch.
                req_o.write <= 1'b0;
                req_o.instr <= 1'b1;
                req_o.id    <= FETCH_ID;
            end
        end
    end

endmodule

// File: hdl/axi_read_master.sv
`timescale 1ns/1ps

module axi_read_master import axi_bridge_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,

    input  bus_req_t req_i,
    input  logic     req_valid_i,

    output axi_ax_t  axi_ar_o,
    output logic     axi_ar_valid_o,
    input  logic     axi_ar_ready_i,

    input  axi_r_t   axi_r_i,
    input  logic     axi_r_valid_i,
    output logic     axi_r_ready_o,

    output bus_rsp_t rsp_o,
    output logic     rd_done_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } rd_state_e;

    rd_state_e state_q;
    logic      r_fire;

    assign axi_ar_o       = make_ax(req_i);     // Request is stable while granted.
    assign axi_ar_valid_o = (state_q == ADDR);
    assign axi_r_ready_o  = (state_q == DATA);
    assign r_fire         = axi_r_valid_i && axi_r_ready_o;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            rd_done_o <= 1'b0;
        end else begin
            rd_done_o <= r_fire;
            case (state_q)
                IDLE: begin
                    if (req_valid_i && !req_i.write) begin
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (axi_ar_ready_i) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (axi_r_valid_i) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (!req_valid_i) begin
                        state_q <= IDLE;    // Arbiter has dropped the grant.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (r_fire) begin
            rsp_o.rdata <= axi_r_i.data;
            rsp_o.resp  <= axi_r_i.resp;
            rsp_o.id    <= axi_r_i.id;
        end
    end

endmodule

// File: hdl/axi_write_master.sv
`timescale 1ns/1ps

module axi_write_master import axi_bridge_pkg::*; (
    input  logic     clock,
    input  logic     rst_n_i,

    input  bus_req_t req_i,
    input  logic     req_valid_i,

    output axi_ax_t  axi_aw_o,
    output logic     axi_aw_valid_o,
    input  logic     axi_aw_ready_i,

    output axi_w_t   axi_w_o,
    output logic     axi_w_valid_o,
    input  logic     axi_w_ready_i,

    input  axi_b_t   axi_b_i,
    input  logic     axi_b_valid_i,
    output logic     axi_b_ready_o,

    output bus_rsp_t rsp_o,
    output logic     wr_done_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        DONE
    } wr_state_e;

    wr_state_e state_q;
    strb_t     base_strb;
    logic      aw_pend;
    logic      w_pend;
    logic      b_fire;

    always_comb begin
        case (req_i.size)
            2'd0:    base_strb = 8'h01;
            2'd1:    base_strb = 8'h03;
            2'd2:    base_strb = 8'h0f;
            default: base_strb = 8'hff;
        endcase
    end

    assign axi_aw_o      = make_ax(req_i);
    assign axi_w_o.data  = req_i.wdata << {req_i.addr[2:0], 3'b000};  // Move into lanes.
    assign axi_w_o.strb  = base_strb << req_i.addr[2:0];
    assign axi_w_o.last  = 1'b1;

    // Channel still waiting after this cycle.
    assign aw_pend       = axi_aw_valid_o && !axi_aw_ready_i;
    assign w_pend        = axi_w_valid_o && !axi_w_ready_i;

    assign axi_b_ready_o = (state_q == RESP);
    assign b_fire        = axi_b_valid_i && axi_b_ready_o;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q        <= IDLE;
            axi_aw_valid_o <= 1'b0;
            axi_w_valid_o  <= 1'b0;
            wr_done_o      <= 1'b0;
        end else begin
            wr_done_o <= b_fire;
            case (state_q)
                IDLE: begin
                    if (req_valid_i && req_i.write) begin
                        state_q        <= ADDR;
                        axi_aw_valid_o <= 1'b1;
                        axi_w_valid_o  <= 1'b1;
                    end
                end
                ADDR: begin
                    axi_aw_valid_o <= aw_pend;
                    axi_w_valid_o  <= w_pend;
                    if (!aw_pend && !w_pend) begin
                        state_q <= RESP;    // Both handshakes seen.
                    end
                end
                RESP: begin
                    if (axi_b_valid_i) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (!req_valid_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (b_fire) begin
            rsp_o.rdata <= '0;
            rsp_o.resp  <= axi_b_i.resp;
            rsp_o.id    <= axi_b_i.id;
        end
    end

endmodule

// File: hdl/resp_router.sv
`timescale 1ns/1ps

module resp_router import axi_bridge_pkg::*; #(
    parameter axi_id_t FETCH_ID = 4'd0,
    parameter axi_id_t DATA_ID  = 4'd1
) (
    input  logic     clock,
    input  logic     rst_n_i,

    input  bus_req_t req_i,
    input  bus_rsp_t rd_rsp_i,
    input  logic     rd_done_i,
    input  bus_rsp_t wr_rsp_i,
    input  logic     wr_done_i,

    output logic     release_o,

    output logic     if_data_valid_o,
    output data_t    if_data_o,
    output logic     mem_rw_ready_o,
    output data_t    mem_data_read_o,
    output resp_t    mem_rw_resp_o
);

    bus_rsp_t rsp;
    logic     done;
    logic     to_fetch;
    logic     to_data;
    data_t    lane_mask;
    data_t    aligned;

    assign done     = rd_done_i || wr_done_i;
    assign rsp      = rd_done_i ? rd_rsp_i : wr_rsp_i;
    assign to_fetch = (rsp.id == FETCH_ID);
    assign to_data  = (rsp.id == DATA_ID) || !to_fetch;    // Unknown IDs go to the data port.

    always_comb begin
        case (req_i.size)
            2'd0:    lane_mask = 64'h0000_0000_0000_00ff;
            2'd1:    lane_mask = 64'h0000_0000_0000_ffff;
            2'd2:    lane_mask = 64'h0000_0000_ffff_ffff;
            default: lane_mask = '1;
        endcase
    end

    assign aligned = (rsp.rdata >> {req_i.addr[2:0], 3'b000}) & lane_mask;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            release_o       <= 1'b0;
            if_data_valid_o <= 1'b0;
            mem_rw_ready_o  <= 1'b0;
        end else begin
            release_o       <= done;
            if_data_valid_o <= done && to_fetch;
            mem_rw_ready_o  <= done && to_data;
        end
    end

    always_ff @(posedge clock) begin
        if (done && to_fetch) begin
            if_data_o <= aligned;
        end
        if (done && to_data) begin
            mem_data_read_o <= aligned;
            mem_rw_resp_o   <= rsp.resp;
        end
    end

endmodule

// File: hdl/axi_bridge_top.sv
`timescale 1ns/1ps

module axi_bridge_top import axi_bridge_pkg::*; #(
    parameter axi_id_t FETCH_ID = 4'd0,
    parameter axi_id_t DATA_ID  = 4'd1
) (
    input  logic        clock,
    input  logic        rst_n_i,

    input  logic        if_addr_valid_i,
    input  logic [63:0] if_rd_addr_i,
    output logic        if_data_valid_o,
    output data_t       if_data_o,

    input  logic        mem_rw_valid_i,
    input  logic        mem_rw_req_i,       // High for a store.
    input  logic [63:0] mem_rw_addr_i,
    input  size_t       mem_rw_size_i,
    input  data_t       mem_data_write_i,
    output logic        mem_rw_ready_o,
    output data_t       mem_data_read_o,
    output resp_t       mem_rw_resp_o,

    output axi_ax_t     axi_aw_o,
    output logic        axi_aw_valid_o,
    input  logic        axi_aw_ready_i,
    output axi_w_t      axi_w_o,
    output logic        axi_w_valid_o,
    input  logic        axi_w_ready_i,
    input  axi_b_t      axi_b_i,
    input  logic        axi_b_valid_i,
    output logic        axi_b_ready_o,
    output axi_ax_t     axi_ar_o,
    output logic        axi_ar_valid_o,
    input  logic        axi_ar_ready_i,
    input  axi_r_t      axi_r_i,
    input  logic        axi_r_valid_i,
    output logic        axi_r_ready_o
);

    bus_req_t req;
    logic     req_valid;
    logic     release_req;
    bus_rsp_t rd_rsp;
    logic     rd_done;
    bus_rsp_t wr_rsp;
    logic     wr_done;

    req_arbiter #(
        .FETCH_ID         (FETCH_ID),
        .DATA_ID          (DATA_ID)
    ) u_arbiter (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .if_addr_valid_i  (if_addr_valid_i),
        .if_rd_addr_i     (if_rd_addr_i),
        .mem_rw_valid_i   (mem_rw_valid_i),
        .mem_rw_req_i     (mem_rw_req_i),
        .mem_rw_addr_i    (mem_rw_addr_i),
        .mem_rw_size_i    (mem_rw_size_i),
        .mem_data_write_i (mem_data_write_i),
        .release_i        (release_req),
        .req_o            (req),
        .req_valid_o      (req_valid)
    );

    axi_read_master u_read (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .req_i            (req),
        .req_valid_i      (req_valid),
        .axi_ar_o         (axi_ar_o),
        .axi_ar_valid_o   (axi_ar_valid_o),
        .axi_ar_ready_i   (axi_ar_ready_i),
        .axi_r_i          (axi_r_i),
        .axi_r_valid_i    (axi_r_valid_i),
        .axi_r_ready_o    (axi_r_ready_o),
        .rsp_o            (rd_rsp),
        .rd_done_o        (rd_done)
    );

    axi_write_master u_write (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .req_i            (req),
        .req_valid_i      (req_valid),
        .axi_aw_o         (axi_aw_o),
        .axi_aw_valid_o   (axi_aw_valid_o),
        .axi_aw_ready_i   (axi_aw_ready_i),
        .axi_w_o          (axi_w_o),
        .axi_w_valid_o    (axi_w_valid_o),
        .axi_w_ready_i    (axi_w_ready_i),
        .axi_b_i          (axi_b_i),
        .axi_b_valid_i    (axi_b_valid_i),
        .axi_b_ready_o    (axi_b_ready_o),
        .rsp_o            (wr_rsp),
        .wr_done_o        (wr_done)
    );

    resp_router #(
        .FETCH_ID         (FETCH_ID),
        .DATA_ID          (DATA_ID)
    ) u_router (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .req_i            (req),
        .rd_rsp_i         (rd_rsp),
        .rd_done_i        (rd_done),
        .wr_rsp_i         (wr_rsp),
        .wr_done_i        (wr_done),
        .release_o        (release_req),
        .if_data_valid_o  (if_data_valid_o),
        .if_data_o        (if_data_o),
        .mem_rw_ready_o   (mem_rw_ready_o),
        .mem_data_read_o  (mem_data_read_o),
        .mem_rw_resp_o    (mem_rw_resp_o)
    );

endmodule

// File: verification/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave import axi_bridge_pkg::*; #(
    parameter int DEPTH = 512
) (
    input  logic    clock,
    input  logic    rst_n_i,
    input  axi_ax_t axi_aw_i,
    input  logic    axi_aw_valid_i,
    output logic    axi_aw_ready_o,
    input  axi_w_t  axi_w_i,
    input  logic    axi_w_valid_i,
    output logic    axi_w_ready_o,
    output axi_b_t  axi_b_o,
    output logic    axi_b_valid_o,
    input  logic    axi_b_ready_i,
    input  axi_ax_t axi_ar_i,
    input  logic    axi_ar_valid_i,
    output logic    axi_ar_ready_o,
    output axi_r_t  axi_r_o,
    output logic    axi_r_valid_o,
    input  logic    axi_r_ready_i,
    output int      stall_errors_o
);

    data_t   mem [DEPTH];       // Filled by the testbench.
    integer  seed = 30155;
    int      ar_wait;
    int      r_wait;
    int      aw_wait;
    int      w_wait;
    int      b_wait;
    int      k;
    logic    rd_pend;
    logic    aw_got;
    logic    w_got;
    logic    ar_stall;
    logic    aw_stall;
    logic    w_stall;
    axi_ax_t ar_hold;
    axi_ax_t aw_hold;
    axi_w_t  w_hold;
    axi_ax_t ar_q;
    axi_ax_t aw_q;
    axi_w_t  w_q;
    axi_r_t  r_beat;
    axi_b_t  b_beat;

    function automatic logic mapped(addr_t addr);
        return addr < DEPTH * 8;
    endfunction

    task automatic note_stall(input string chan);
        $display("AXI %s payload changed during a stall at %0t", chan, $time);
        stall_errors_o++;
    endtask

    initial begin
        stall_errors_o = 0;
        axi_aw_ready_o = 1'b0;
        axi_w_ready_o  = 1'b0;
        axi_ar_ready_o = 1'b0;
        axi_b_valid_o  = 1'b0;
        axi_r_valid_o  = 1'b0;
        axi_b_o        = '0;
        axi_r_o        = '0;
        rd_pend        = 1'b0;
        aw_got         = 1'b0;
        w_got          = 1'b0;
        ar_wait        = $random(seed) & 3;
        r_wait         = $random(seed) & 3;
        aw_wait        = $random(seed) & 3;
        w_wait         = $random(seed) & 3;
        b_wait         = $random(seed) & 3;
    end

    // Outputs change 1 ns after the edge.
    always @(posedge clock) begin
        if (rst_n_i) begin
            if (ar_stall && (!axi_ar_valid_i || axi_ar_i !== ar_hold)) begin
                note_stall("AR");
            end
            if (aw_stall && (!axi_aw_valid_i || axi_aw_i !== aw_hold)) begin
                note_stall("AW");
            end
            if (w_stall && (!axi_w_valid_i || axi_w_i !== w_hold)) begin
                note_stall("W");
            end
            ar_stall = axi_ar_valid_i && !axi_ar_ready_o;
            aw_stall = axi_aw_valid_i && !axi_aw_ready_o;
            w_stall  = axi_w_valid_i && !axi_w_ready_o;
            ar_hold  = axi_ar_i;
            aw_hold  = axi_aw_i;
            w_hold   = axi_w_i;

            if (axi_ar_valid_i && axi_ar_ready_o) begin
                ar_q    = axi_ar_i;
                rd_pend = 1'b1;
                ar_wait = $random(seed) & 3;
                axi_ar_ready_o <= #1 1'b0;
            end else if (axi_ar_valid_i && !rd_pend) begin
                if (ar_wait == 0) begin
                    axi_ar_ready_o <= #1 1'b1;
                end else begin
                    ar_wait--;
                end
            end

            if (axi_r_valid_o && axi_r_ready_i) begin
                rd_pend = 1'b0;
                r_wait  = $random(seed) & 3;
                axi_r_valid_o <= #1 1'b0;
            end else if (rd_pend && !axi_r_valid_o) begin
                if (r_wait == 0) begin
                    r_beat.data = mapped(ar_q.addr) ? mem[ar_q.addr >> 3] : '0;
                    r_beat.id   = ar_q.id;
                    r_beat.resp = mapped(ar_q.addr) ? RESP_OKAY : RESP_DECERR;
                    r_beat.last = 1'b1;
                    axi_r_o       <= #1 r_beat;
                    axi_r_valid_o <= #1 1'b1;
                end else begin
                    r_wait--;
                end
            end

            if (axi_aw_valid_i && axi_aw_ready_o) begin
                aw_q    = axi_aw_i;
                aw_got  = 1'b1;
                aw_wait = $random(seed) & 3;
                axi_aw_ready_o <= #1 1'b0;
            end else if (axi_aw_valid_i && !aw_got) begin
                if (aw_wait == 0) begin
                    axi_aw_ready_o <= #1 1'b1;
                end else begin
                    aw_wait--;
                end
            end

            if (axi_w_valid_i && axi_w_ready_o) begin
                w_q    = axi_w_i;
                w_got  = 1'b1;
                w_wait = $random(seed) & 3;
                axi_w_ready_o <= #1 1'b0;
            end else if (axi_w_valid_i && !w_got) begin
                if (w_wait == 0) begin
                    axi_w_ready_o <= #1 1'b1;
                end else begin
                    w_wait--;
                end
            end

            if (axi_b_valid_o && axi_b_ready_i) begin
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_wait = $random(seed) & 3;
                axi_b_valid_o <= #1 1'b0;
            end else if (aw_got && w_got && !axi_b_valid_o) begin
                if (b_wait == 0) begin
                    if (mapped(aw_q.addr)) begin
                        for (k = 0; k < 8; k++) begin
                            if (w_q.strb[k]) begin
                                mem[aw_q.addr >> 3][8 * k +: 8] = w_q.data[8 * k +: 8];
                            end
                        end
                    end
                    b_beat.id   = aw_q.id;
                    b_beat.resp = mapped(aw_q.addr) ? RESP_OKAY : RESP_DECERR;
                    axi_b_o       <= #1 b_beat;
                    axi_b_valid_o <= #1 1'b1;
                end else begin
                    b_wait--;
                end
            end
        end
    end

endmodule

// File: verification/tb_axi_bridge_top.sv
`timescale 1ns/1ps

module tb_axi_bridge_top import axi_bridge_pkg::*; ();

    localparam int      CLK_PERIOD = 20;
    localparam int      MEM_WORDS  = 512;
    localparam int      MEM_LIMIT  = MEM_WORDS * 8;     // First unmapped byte.
    localparam int      TOTAL_OPS  = 130;
    localparam int      OP_TIMEOUT = 200;
    localparam axi_id_t FETCH_ID   = 4'd3;
    localparam axi_id_t DATA_ID    = 4'd5;

    logic        clock;
    logic        rst_n_i;
    logic        if_addr_valid_i;
    logic [63:0] if_rd_addr_i;
    logic        if_data_valid_o;
    data_t       if_data_o;
    logic        mem_rw_valid_i;
    logic        mem_rw_req_i;
    logic [63:0] mem_rw_addr_i;
    size_t       mem_rw_size_i;
    data_t       mem_data_write_i;
    logic        mem_rw_ready_o;
    data_t       mem_data_read_o;
    resp_t       mem_rw_resp_o;
    axi_ax_t     axi_aw_o;
    logic        axi_aw_valid_o;
    logic        axi_aw_ready_i;
    axi_w_t      axi_w_o;
    logic        axi_w_valid_o;
    logic        axi_w_ready_i;
    axi_b_t      axi_b_i;
    logic        axi_b_valid_i;
    logic        axi_b_ready_o;
    axi_ax_t     axi_ar_o;
    logic        axi_ar_valid_o;
    logic        axi_ar_ready_i;
    axi_r_t      axi_r_i;
    logic        axi_r_valid_i;
    logic        axi_r_ready_o;
    int          stall_errors;

    integer      seed = 30155;
    int          errors = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    data_t       mirror [MEM_WORDS];

    axi_bridge_top #(
        .FETCH_ID (FETCH_ID),
        .DATA_ID  (DATA_ID)
    ) i_dut (.*);

    axi_mem_slave #(
        .DEPTH          (MEM_WORDS)
    ) i_mem (
        .clock          (clock),
        .rst_n_i        (rst_n_i),
        .axi_aw_i       (axi_aw_o),
        .axi_aw_valid_i (axi_aw_valid_o),
        .axi_aw_ready_o (axi_aw_ready_i),
        .axi_w_i        (axi_w_o),
        .axi_w_valid_i  (axi_w_valid_o),
        .axi_w_ready_o  (axi_w_ready_i),
        .axi_b_o        (axi_b_i),
        .axi_b_valid_o  (axi_b_valid_i),
        .axi_b_ready_i  (axi_b_ready_o),
        .axi_ar_i       (axi_ar_o),
        .axi_ar_valid_i (axi_ar_valid_o),
        .axi_ar_ready_o (axi_ar_ready_i),
        .axi_r_o        (axi_r_i),
        .axi_r_valid_o  (axi_r_valid_i),
        .axi_r_ready_i  (axi_r_ready_o),
        .stall_errors_o (stall_errors)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        #(TOTAL_OPS * 200 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without finishing", TOTAL_OPS * 200);
        $display("Test failed");
        $finish;
    end

    function automatic data_t fill_word(int idx);
        return {32'h5a00_0000 ^ idx, idx * 32'h9e37_79b1};
    endfunction

    function automatic logic in_range(addr_t addr);
        return addr < MEM_LIMIT;
    endfunction

    function automatic addr_t rand_addr(size_t size, int span);
        addr_t a;
        a = $unsigned($random(seed)) % span;
        return a & ~((32'd1 << size) - 1);     // Natural alignment.
    endfunction

    // Bytes of one access taken from the mirror, zero-extended.
    function automatic data_t expected_lane(addr_t addr, size_t size);
        data_t lane;
        int    b;
        lane = '0;
        if (in_range(addr)) begin
            for (b = 0; b < (1 << size); b++) begin
                lane[8 * b +: 8] = mirror[addr >> 3][8 * (addr[2:0] + b) +: 8];
            end
        end
        return lane;
    endfunction

    function automatic void store_bytes(addr_t addr, size_t size, data_t wdata);
        int b;
        for (b = 0; b < (1 << size); b++) begin
            mirror[addr >> 3][8 * (addr[2:0] + b) +: 8] = wdata[8 * b +: 8];
        end
    endfunction

    task automatic flag_mismatch(input string what, input addr_t addr, input data_t got,
                                 input data_t exp);
        $display("MISMATCH at %0t: %s at %h got %h expected %h", $time, what, addr, got, exp);
        errors++;
    endtask

    // Single beat INCR with the attributes of the requesting port.
    task automatic check_addr_phase(input string what, input axi_ax_t ax, input logic fetch);
        axi_ax_t exp;
        exp.addr  = fetch ? if_rd_addr_i[31:0] : mem_rw_addr_i[31:0];
        exp.id    = fetch ? FETCH_ID : DATA_ID;
        exp.prot  = fetch ? 3'b100 : 3'b000;
        exp.len   = 8'd0;
        exp.size  = fetch ? 3'd2 : {1'b0, mem_rw_size_i};
        exp.burst = 2'b01;
        if (ax !== exp) begin
            flag_mismatch(what, ax.addr, data_t'(ax), data_t'(exp));
        end
    endtask

    always @(posedge clock) begin
        if (rst_n_i) begin
            if (axi_ar_valid_o && axi_ar_ready_i) begin
                check_addr_phase("AR payload", axi_ar_o, axi_ar_o.id == FETCH_ID);
            end
            if (axi_aw_valid_o && axi_aw_ready_i) begin
                check_addr_phase("AW payload", axi_aw_o, 1'b0);
            end
            if (axi_w_valid_o && axi_w_ready_i && axi_w_o.last !== 1'b1) begin
                $display("MISMATCH at %0t: W beat accepted without last set", $time);
                errors++;
            end
        end
    end

    task automatic report_test(input string name, input int first_error);
        if (errors == first_error) begin
            $display("%s: PASS", name);
            tests_pass++;
        end else begin
            $display("%s: FAIL with %0d errors", name, errors - first_error);
            tests_fail++;
        end
    endtask

    // One request on one port, held until its completion pulse.
    task automatic access_port(input logic fetch, input logic write, input addr_t addr,
                               input size_t size, input data_t wdata);
        data_t exp_data;
        resp_t exp_resp;
        data_t got_data;
        resp_t got_resp;
        logic  seen;
        int    cyc;
        exp_data = write ? '0 : expected_lane(addr, fetch ? 2'd2 : size);
        exp_resp = in_range(addr) ? RESP_OKAY : RESP_DECERR;
        seen     = 1'b0;
        @(posedge clock);
        #1;
        if (fetch) begin
            if_addr_valid_i = 1'b1;
            if_rd_addr_i    = {32'd0, addr};
        end else begin
            mem_rw_valid_i   = 1'b1;
            mem_rw_req_i     = write;
            mem_rw_addr_i    = {32'd0, addr};
            mem_rw_size_i    = size;
            mem_data_write_i = wdata;
        end
        for (cyc = 0; cyc < OP_TIMEOUT && !seen; cyc++) begin
            @(posedge clock);
            seen     = fetch ? if_data_valid_o : mem_rw_ready_o;
            got_data = fetch ? if_data_o : mem_data_read_o;
            got_resp = mem_rw_resp_o;
        end
        #1;
        if_addr_valid_i = 1'b0;
        mem_rw_valid_i  = 1'b0;
        if (!seen) begin
            $display("Timeout at %0t: no completion pulse for access at %h", $time, addr);
            errors++;
        end else begin
            if (!write && got_data !== exp_data) begin
                flag_mismatch(fetch ? "fetch data" : "load data", addr, got_data, exp_data);
            end
            if (!fetch && got_resp !== exp_resp) begin
                flag_mismatch("response", addr, data_t'(got_resp), data_t'(exp_resp));
            end
        end
        if (write && in_range(addr)) begin
            store_bytes(addr, size, wdata);
        end
    endtask

    // Both ports raised in the same idle cycle.
    task automatic contention_pair(input addr_t faddr, input addr_t daddr);
        data_t fexp;
        data_t dexp;
        int    cyc;
        int    fetch_at;
        int    data_at;
        fexp     = expected_lane(faddr, 2'd2);
        dexp     = expected_lane(daddr, 2'd3);
        fetch_at = -1;
        data_at  = -1;
        @(posedge clock);
        #1;
        if_addr_valid_i = 1'b1;
        if_rd_addr_i    = {32'd0, faddr};
        mem_rw_valid_i  = 1'b1;
        mem_rw_req_i    = 1'b0;
        mem_rw_addr_i   = {32'd0, daddr};
        mem_rw_size_i   = 2'd3;
        for (cyc = 0; cyc < 2 * OP_TIMEOUT && (fetch_at < 0 || data_at < 0); cyc++) begin
            @(posedge clock);
            if (mem_rw_ready_o && data_at < 0) begin
                data_at = cyc;
                if (mem_data_read_o !== dexp) begin
                    flag_mismatch("contended load", daddr, mem_data_read_o, dexp);
                end
                if (mem_rw_resp_o !== RESP_OKAY) begin
                    flag_mismatch("contended response", daddr, data_t'(mem_rw_resp_o),
                                  data_t'(RESP_OKAY));
                end
            end
            if (if_data_valid_o && fetch_at < 0) begin
                fetch_at = cyc;
                if (if_data_o !== fexp) begin
                    flag_mismatch("contended fetch", faddr, if_data_o, fexp);
                end
            end
            #1;
            if (data_at >= 0) begin
                mem_rw_valid_i = 1'b0;
            end
            if (fetch_at >= 0) begin
                if_addr_valid_i = 1'b0;
            end
        end
        if_addr_valid_i = 1'b0;
        mem_rw_valid_i  = 1'b0;
        if (fetch_at < 0 || data_at < 0) begin
            $display("Timeout at %0t: contended requests did not both complete", $time);
            errors++;
        end else if (data_at >= fetch_at) begin
            $display("Fetch completed before the data port under contention");
            errors++;
        end
    endtask

    initial begin
        int    i;
        int    first;
        addr_t a;
        size_t s;
        if_addr_valid_i  = 1'b0;
        if_rd_addr_i     = '0;
        mem_rw_valid_i   = 1'b0;
        mem_rw_req_i     = 1'b0;
        mem_rw_addr_i    = '0;
        mem_rw_size_i    = '0;
        mem_data_write_i = '0;
        rst_n_i          = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mirror[i]    = fill_word(i);
            i_mem.mem[i] = fill_word(i);
        end
        repeat (2) @(posedge clock);
        #1;
        rst_n_i = 1'b1;

        first = errors;
        for (i = 0; i < 40; i++) begin
            access_port(1'b1, 1'b0, rand_addr(2'd2, MEM_LIMIT), 2'd2, '0);
        end
        report_test("Test 1 fetch", first);

        first = errors;
        for (i = 0; i < 30; i++) begin
            s = size_t'($random(seed) & 3);
            a = rand_addr(s, MEM_LIMIT);
            access_port(1'b0, 1'b1, a, s, {$random(seed), $random(seed)});
            s = size_t'($random(seed) & 3);
            a = {a[31:3], 3'b000} | rand_addr(s, 8);    // Same doubleword.
            access_port(1'b0, 1'b0, a, s, '0);
        end
        report_test("Test 2 write then read", first);

        first = errors;
        contention_pair(rand_addr(2'd2, MEM_LIMIT), rand_addr(2'd3, MEM_LIMIT));
        report_test("Test 3 contention", first);

        first = errors;
        for (i = 0; i < 2; i++) begin
            a = MEM_LIMIT + rand_addr(2'd3, MEM_LIMIT);
            access_port(1'b0, 1'b1, a, 2'd3, {$random(seed), $random(seed)});
            access_port(1'b0, 1'b0, a, 2'd3, '0);
            access_port(1'b0, 1'b0, a - MEM_LIMIT, 2'd3, '0);  // Possible alias.
            access_port(1'b1, 1'b0, a, 2'd2, '0);
        end
        report_test("Test 4 decode error", first);

        first = errors;
        for (i = 0; i < 20; i++) begin
            s = size_t'($random(seed) & 3);
            a = rand_addr(s, MEM_LIMIT);
            case ($unsigned($random(seed)) % 3)
                0: access_port(1'b1, 1'b0, {a[31:2], 2'b00}, 2'd2, '0);
                1: access_port(1'b0, 1'b1, a, s, {$random(seed), $random(seed)});
                default: access_port(1'b0, 1'b0, a, s, '0);
            endcase
        end
        if (stall_errors != 0) begin
            $display("AXI payloads changed during a stall %0d times", stall_errors);
            errors++;
        end
        report_test("Test 5 back-pressure", first);

        $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/axi_bridge_pkg.sv
hdl/req_arbiter.sv
hdl/axi_read_master.sv
hdl/axi_write_master.sv
hdl/resp_router.sv
hdl/axi_bridge_top.sv
verification/axi_mem_slave.sv
verification/tb_axi_bridge_top.sv

// File: Bender.yml
package:
  name: axi_bridge

sources:
  - files:
      - hdl/axi_bridge_pkg.sv
      - hdl/req_arbiter.sv
      - hdl/axi_read_master.sv
      - hdl/axi_write_master.sv
      - hdl/resp_router.sv
      - hdl/axi_bridge_top.sv
  - target: test
    files:
      - verification/axi_mem_slave.sv
      - verification/tb_axi_bridge_top.sv
